// ==== ptp_traffic_ctrl.f ====
common/ptp_tc_pkg.sv
csr/ptp_csr_decode.sv
measure/ptp_avg.sv
measure/ptp_capture.sv
rtl/ptp_error_monitor.sv
rtl/ptp_traffic_ctrl.sv
sim/tb_ptp_traffic_ctrl.sv

// ==== sim/tb_ptp_traffic_ctrl.sv ====
`timescale 1ns/1ps

module tb_ptp_traffic_ctrl;
	import ptp_tc_pkg::*;

	localparam int AVG_LOG2 = 2;
	localparam int CAPT_ADDR_W = 3;
	localparam int AVG_COUNT = 2 ** AVG_LOG2;
	localparam int CAPT_DEPTH = 2 ** CAPT_ADDR_W;
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk;
	logic reset_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [7:0] wb_adr;
	logic [CSR_DW-1:0] wb_dat_w;
	logic [CSR_DW-1:0] wb_dat_r;
	logic wb_ack;
	logic sample_valid;
	logic sample_ready;
	logic [SAMPLE_W-1:0] offset_sample;
	logic [SAMPLE_W-1:0] delay_sample;
	logic master_rx_valid;
	logic [5:0] master_rx_error;
	logic slave_rx_valid;
	logic [5:0] slave_rx_error;
	logic [1:0] channel_ready;
	logic [1:0] start_tod_sync;
	logic error_n;

	integer seed;
	int errors;
	int checks;
	int cycle_count = 0;
	logic [FNSEC_W-1:0] exp_ofs [CAPT_DEPTH];
	logic [FNSEC_W-1:0] exp_dly [CAPT_DEPTH];

	ptp_traffic_ctrl #(
		.AVG_LOG2(AVG_LOG2),
		.CAPT_ADDR_W(CAPT_ADDR_W)
	) uut (
		.clk(clk),
		.reset_n(reset_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.offset_sample(offset_sample),
		.delay_sample(delay_sample),
		.master_rx_valid(master_rx_valid),
		.master_rx_error(master_rx_error),
		.slave_rx_valid(slave_rx_valid),
		.slave_rx_error(slave_rx_error),
		.channel_ready(channel_ready),
		.start_tod_sync(start_tod_sync),
		.error_n(error_n)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [63:0] got,
			input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [FNSEC_W-1:0] rand_fnsec();
		logic [63:0] r;
		r = {$random(seed), $random(seed)};
		return r[FNSEC_W-1:0];
	endfunction

	task automatic reset_dut();
		@(posedge clk);
		reset_n <= 1'b0;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
	endtask

	// Returns on the edge where ack is seen, stb drops there
	task automatic wb_write(input logic [CSR_AW-1:0] addr, input logic [CSR_DW-1:0] data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= {addr, 2'b00};
		wb_dat_w <= data;
		@(posedge clk);
		while (!wb_ack)
			@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic wb_read(input logic [CSR_AW-1:0] addr, output logic [CSR_DW-1:0] data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= {addr, 2'b00};
		@(posedge clk);
		while (!wb_ack)
			@(posedge clk);
		data = wb_dat_r;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic send_sample(input logic [SAMPLE_W-1:0] ofs, input logic [SAMPLE_W-1:0] dly);
		@(posedge clk);
		sample_valid <= 1'b1;
		offset_sample <= ofs;
		delay_sample <= dly;
		@(posedge clk);
		while (!sample_ready)
			@(posedge clk);
		sample_valid <= 1'b0;
	endtask

	task automatic test_control();
		logic [CSR_DW-1:0] rd;
		wb_write(REG_CTRL, 32'hffff_ffff);
		wb_read(REG_CTRL, rd);
		check_value("ctrl readback all ones", rd, 32'h37);
		check_value("start_tod_sync", start_tod_sync, 2'b11);
		wb_write(REG_CTRL, 32'h20);
		wb_read(REG_CTRL, rd);
		check_value("ctrl readback", rd, 32'h20);
		check_value("start_tod_sync", start_tod_sync, 2'b10);
		wb_write(REG_CTRL, 32'h0);
		check_value("start_tod_sync cleared", start_tod_sync, 2'b00);
	endtask

	task automatic test_averages();
		logic [FNSEC_W-1:0] ofs;
		logic [FNSEC_W-1:0] dly;
		longint sum_ofs;
		longint sum_dly;
		logic [63:0] mean_ofs;
		logic [63:0] mean_dly;
		logic [CSR_DW-1:0] rd;
		sum_ofs = 0;
		sum_dly = 0;
		for (int i = 0; i < AVG_COUNT; i++) begin
			ofs = rand_fnsec();
			dly = rand_fnsec();
			sum_ofs = sum_ofs + longint'(signed'(ofs));
			sum_dly = sum_dly + longint'(signed'(dly));
			send_sample({48'h0, ofs}, {48'h0, dly});
		end
		// Mean rounds toward minus infinity
		mean_ofs = sum_ofs >>> AVG_LOG2;
		mean_dly = sum_dly >>> AVG_LOG2;
		wb_read(REG_AVG_OFS_LO, rd);
		check_value("avg offset lo", rd, mean_ofs[31:0]);
		wb_read(REG_AVG_OFS_HI, rd);
		check_value("avg offset hi", rd, {16'h0, mean_ofs[47:32]});
		wb_read(REG_AVG_DLY_LO, rd);
		check_value("avg delay lo", rd, mean_dly[31:0]);
		wb_read(REG_AVG_DLY_HI, rd);
		check_value("avg delay hi", rd, {16'h0, mean_dly[47:32]});
		wb_read(REG_STATUS, rd);
		check_value("sec_error status", rd[3], 1'b0);
		check_value("error_n", error_n, 1'b1);
	endtask

	task automatic test_sec_range();
		logic [CSR_DW-1:0] rd;
		send_sample({48'd2, rand_fnsec()}, {48'h0, rand_fnsec()});
		wb_read(REG_STATUS, rd);
		check_value("sec_error status", rd[3], 1'b1);
		check_value("error_n", error_n, 1'b0);
	endtask

	task automatic test_capture();
		logic [CSR_DW-1:0] rd;
		@(posedge clk);
		channel_ready <= 2'b11;
		repeat (4) @(posedge clk);
		// Enabled but not started, a full run of samples
		wb_write(REG_CTRL, 32'h2);
		for (int i = 0; i < CAPT_DEPTH; i++)
			send_sample({48'h0, rand_fnsec()}, {48'h0, rand_fnsec()});
		wb_read(REG_STATUS, rd);
		check_value("capt_done without go", rd[0], 1'b0);
		wb_write(REG_CTRL, 32'h3);
		for (int i = 0; i < CAPT_DEPTH; i++) begin
			exp_ofs[i] = rand_fnsec();
			exp_dly[i] = rand_fnsec();
			send_sample({48'h0, exp_ofs[i]}, {48'h0, exp_dly[i]});
		end
		wb_read(REG_STATUS, rd);
		check_value("capt_done after run", rd[0], 1'b1);
		wb_write(REG_CTRL, 32'h7);
		check_value("sample_ready in read mode", sample_ready, 1'b0);
		for (int i = 0; i < CAPT_DEPTH; i++) begin
			wb_write(REG_MEM_ADDR, i);
			wb_read(REG_MEM_OFS_LO, rd);
			check_value($sformatf("mem offset lo %0d", i), rd, exp_ofs[i][31:0]);
			wb_read(REG_MEM_OFS_HI, rd);
			check_value($sformatf("mem offset hi %0d", i), rd, {16'h0, exp_ofs[i][47:32]});
			wb_read(REG_MEM_DLY_LO, rd);
			check_value($sformatf("mem delay lo %0d", i), rd, exp_dly[i][31:0]);
			wb_read(REG_MEM_DLY_HI, rd);
			check_value($sformatf("mem delay hi %0d", i), rd, {16'h0, exp_dly[i][47:32]});
		end
		wb_write(REG_CTRL, 32'h0);
	endtask

	task automatic test_crc_flags();
		logic [CSR_DW-1:0] rd;
		// Sticky sec_error is cleared by reset
		reset_dut();
		check_value("error_n before crc beats", error_n, 1'b1);
		@(posedge clk);
		master_rx_valid <= 1'b1;
		master_rx_error <= 6'b00_0010;
		@(posedge clk);
		master_rx_valid <= 1'b0;
		master_rx_error <= 6'b0;
		wb_read(REG_STATUS, rd);
		check_value("crc_master after master beat", rd[1], 1'b1);
		check_value("crc_slave after master beat", rd[2], 1'b0);
		check_value("error_n after master beat", error_n, 1'b0);
		@(posedge clk);
		slave_rx_valid <= 1'b1;
		slave_rx_error <= 6'b00_0010;
		@(posedge clk);
		slave_rx_valid <= 1'b0;
		slave_rx_error <= 6'b0;
		wb_read(REG_STATUS, rd);
		check_value("crc_master held", rd[1], 1'b1);
		check_value("crc_slave after slave beat", rd[2], 1'b1);
		check_value("error_n", error_n, 1'b0);
	endtask

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		sample_valid = 1'b0;
		offset_sample = '0;
		delay_sample = '0;
		master_rx_valid = 1'b0;
		master_rx_error = '0;
		slave_rx_valid = 1'b0;
		slave_rx_error = '0;
		channel_ready = 2'b00;
		errors = 0;
		checks = 0;
		seed = 32'h8771_2040;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);
		check_value("sample_ready after reset", sample_ready, 1'b1);
		check_value("error_n after reset", error_n, 1'b1);
		test_control();
		test_averages();
		test_sec_range();
		test_capture();
		test_crc_flags();
		repeat (4) @(posedge clk);
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// ==== rtl/ptp_traffic_ctrl.sv ====
`timescale 1ns/1ps

module ptp_traffic_ctrl #(
	parameter int AVG_LOG2 = 4,
	parameter int CAPT_ADDR_W = 6
) (
	input  logic clk,
	input  logic reset_n,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [7:0] wb_adr,
	input  logic [ptp_tc_pkg::CSR_DW-1:0] wb_dat_w,
	output logic [ptp_tc_pkg::CSR_DW-1:0] wb_dat_r,
	output logic wb_ack,
	input  logic sample_valid,
	output logic sample_ready,
	input  logic [ptp_tc_pkg::SAMPLE_W-1:0] offset_sample,
	input  logic [ptp_tc_pkg::SAMPLE_W-1:0] delay_sample,
	input  logic master_rx_valid,
	input  logic [5:0] master_rx_error,
	input  logic slave_rx_valid,
	input  logic [5:0] slave_rx_error,
	input  logic [1:0] channel_ready,
	output logic [1:0] start_tod_sync,
	output logic error_n
);
	import ptp_tc_pkg::*;

	logic go;
	logic capt_ena;
	logic capt_read;
	logic capt_done;
	logic sample_accept;
	logic channels_ready;
	logic crc_master;
	logic crc_slave;
	logic sec_error;
	logic sec_error_ofs;
	logic sec_error_dly;
	logic [CAPT_ADDR_W-1:0] mem_rdaddr;
	logic [FNSEC_W-1:0] avg_ofs;
	logic [FNSEC_W-1:0] avg_dly;
	logic [FNSEC_W-1:0] mem_ofs;
	logic [FNSEC_W-1:0] mem_dly;

	// Byte address to word address
	ptp_csr_decode #(
		.CAPT_ADDR_W(CAPT_ADDR_W)
	) csr_decode (
		.clk(clk),
		.reset_n(reset_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr[7:2]),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.capt_done(capt_done),
		.channels_ready(channels_ready),
		.crc_master(crc_master),
		.crc_slave(crc_slave),
		.sec_error(sec_error),
		.avg_ofs(avg_ofs),
		.avg_dly(avg_dly),
		.mem_ofs(mem_ofs),
		.mem_dly(mem_dly),
		.go(go),
		.capt_ena(capt_ena),
		.capt_read(capt_read),
		.start_tod_sync(start_tod_sync),
		.mem_rdaddr(mem_rdaddr)
	);

	ptp_capture #(
		.CAPT_ADDR_W(CAPT_ADDR_W)
	) capture (
		.clk(clk),
		.reset_n(reset_n),
		.sample_valid(sample_valid),
		.sample_ready(sample_ready),
		.sample_accept(sample_accept),
		.offset_sample(offset_sample),
		.delay_sample(delay_sample),
		.go(go),
		.capt_ena(capt_ena),
		.capt_read(capt_read),
		.channels_ready(channels_ready),
		.mem_rdaddr(mem_rdaddr),
		.capt_done(capt_done),
		.mem_ofs(mem_ofs),
		.mem_dly(mem_dly)
	);

	ptp_avg #(
		.AVG_LOG2(AVG_LOG2)
	) avg_offset (
		.clk(clk),
		.reset_n(reset_n),
		.sample_accept(sample_accept),
		.sample(offset_sample),
		.avg(avg_ofs),
		.sec_error(sec_error_ofs)
	);

	ptp_avg #(
		.AVG_LOG2(AVG_LOG2)
	) avg_delay (
		.clk(clk),
		.reset_n(reset_n),
		.sample_accept(sample_accept),
		.sample(delay_sample),
		.avg(avg_dly),
		.sec_error(sec_error_dly)
	);

	// Either path out of range
	assign sec_error = sec_error_ofs | sec_error_dly;

	ptp_error_monitor error_monitor (
		.clk(clk),
		.reset_n(reset_n),
		.channel_ready(channel_ready),
		.master_rx_valid(master_rx_valid),
		.slave_rx_valid(slave_rx_valid),
		.master_rx_error(master_rx_error),
		.slave_rx_error(slave_rx_error),
		.sec_error(sec_error),
		.channels_ready(channels_ready),
		.crc_master(crc_master),
		.crc_slave(crc_slave),
		.error_n(error_n)
	);

endmodule

// ==== rtl/ptp_error_monitor.sv ====
`timescale 1ns/1ps

module ptp_error_monitor (
	input  logic clk,
	input  logic reset_n,
	input  logic [1:0] channel_ready,
	input  logic master_rx_valid,
	input  logic slave_rx_valid,
	input  logic [5:0] master_rx_error,
	input  logic [5:0] slave_rx_error,
	input  logic sec_error,
	output logic channels_ready,
	output logic crc_master,
	output logic crc_slave,
	output logic error_n
);
	import ptp_tc_pkg::*;

	logic [1:0] ready_meta;
	logic [1:0] ready_sync;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			ready_meta <= 2'b00;
			ready_sync <= 2'b00;
			crc_master <= 1'b0;
			crc_slave <= 1'b0;
		end else begin
			ready_meta <= channel_ready;
			ready_sync <= ready_meta;
			// Sticky until reset
			if (master_rx_valid && master_rx_error[RX_ERR_CRC])
				crc_master <= 1'b1;
			if (slave_rx_valid && slave_rx_error[RX_ERR_CRC])
				crc_slave <= 1'b1;
		end
	end

	assign channels_ready = &ready_sync;
	assign error_n = ~(crc_master | crc_slave | sec_error);

endmodule

// ==== measure/ptp_capture.sv ====
`timescale 1ns/1ps

module ptp_capture #(
	parameter int CAPT_ADDR_W = 6
) (
	input  logic clk,
	input  logic reset_n,
	input  logic sample_valid,
	output logic sample_ready,
	output logic sample_accept,
	input  logic [ptp_tc_pkg::SAMPLE_W-1:0] offset_sample,
	input  logic [ptp_tc_pkg::SAMPLE_W-1:0] delay_sample,
	input  logic go,
	input  logic capt_ena,
	input  logic capt_read,
	input  logic channels_ready,
	input  logic [CAPT_ADDR_W-1:0] mem_rdaddr,
	output logic capt_done,
	output logic [ptp_tc_pkg::FNSEC_W-1:0] mem_ofs,
	output logic [ptp_tc_pkg::FNSEC_W-1:0] mem_dly
);
	import ptp_tc_pkg::*;

	localparam int DEPTH = 2 ** CAPT_ADDR_W;

	ptp_sample_u ofs_in;
	ptp_sample_u dly_in;
	logic [FNSEC_W-1:0] ofs_ram [DEPTH];
	logic [FNSEC_W-1:0] dly_ram [DEPTH];
	logic [CAPT_ADDR_W-1:0] capt_addr;
	logic [CAPT_ADDR_W-1:0] ram_addr;
	logic armed;
	logic ram_we;

	assign ofs_in.raw = offset_sample;
	assign dly_in.raw = delay_sample;

	// Hold off the source while the RAMs are being read back
	assign sample_ready = ~capt_read;
	assign sample_accept = sample_valid & sample_ready;

	assign armed = go & capt_ena & channels_ready;
	assign ram_we = sample_accept & armed & ~capt_done;
	assign ram_addr = capt_read ? mem_rdaddr : capt_addr;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			capt_addr <= '0;
			capt_done <= 1'b0;
		end else if (!capt_ena) begin
			capt_addr <= '0;
			capt_done <= 1'b0;
		end else if (ram_we) begin
			capt_addr <= capt_addr + 1'b1;
			if (&capt_addr)
				capt_done <= 1'b1;
		end
	end

	// Shared address, read-during-write returns old data
	always_ff @(posedge clk) begin
		if (ram_we) begin
			ofs_ram[ram_addr] <= ofs_in.f.fnsec;
			dly_ram[ram_addr] <= dly_in.f.fnsec;
		end
		mem_ofs <= ofs_ram[ram_addr];
		mem_dly <= dly_ram[ram_addr];
	end

	// Counter sits at the wrap point while done
	assert property (@(posedge clk) disable iff (!reset_n)
		capt_done |-> capt_addr == '0)
		else $error("capture address moved after done");

endmodule

// ==== measure/ptp_avg.sv ====
`timescale 1ns/1ps

module ptp_avg #(
	parameter int AVG_LOG2 = 4
) (
	input  logic clk,
	input  logic reset_n,
	input  logic sample_accept,
	input  ptp_tc_pkg::ptp_sample_u sample,
	output logic [ptp_tc_pkg::FNSEC_W-1:0] avg,
	output logic sec_error
);
	import ptp_tc_pkg::*;

	// Headroom for 2^AVG_LOG2 signed terms
	localparam int ACC_W = FNSEC_W + AVG_LOG2;

	logic signed [ACC_W-1:0] sum;
	logic signed [ACC_W-1:0] next_sum;
	logic signed [ACC_W-1:0] mean;
	logic [AVG_LOG2-1:0] count;
	logic sec_bad;

	assign next_sum = sum + {{AVG_LOG2{sample.f.fnsec[FNSEC_W-1]}}, sample.f.fnsec};
	assign mean = next_sum >>> AVG_LOG2;

	// Anything but a sign extension means a second or more
	assign sec_bad = (sample.f.sec != '0) && (sample.f.sec != '1);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sum <= '0;
			count <= '0;
			avg <= '0;
			sec_error <= 1'b0;
		end else if (sample_accept) begin
			count <= count + 1'b1;
			if (&count) begin
				avg <= mean[FNSEC_W-1:0];
				sum <= '0;
			end else begin
				sum <= next_sum;
			end
			if (sec_bad)
				sec_error <= 1'b1;
		end
	end

endmodule

// ==== csr/ptp_csr_decode.sv ====
`timescale 1ns/1ps

module ptp_csr_decode #(
	parameter int CAPT_ADDR_W = 6
) (
	input  logic clk,
	input  logic reset_n,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [ptp_tc_pkg::CSR_AW-1:0] wb_adr,
	input  logic [ptp_tc_pkg::CSR_DW-1:0] wb_dat_w,
	output logic [ptp_tc_pkg::CSR_DW-1:0] wb_dat_r,
	output logic wb_ack,
	input  logic capt_done,
	input  logic channels_ready,
	input  logic crc_master,
	input  logic crc_slave,
	input  logic sec_error,
	input  logic [ptp_tc_pkg::FNSEC_W-1:0] avg_ofs,
	input  logic [ptp_tc_pkg::FNSEC_W-1:0] avg_dly,
	input  logic [ptp_tc_pkg::FNSEC_W-1:0] mem_ofs,
	input  logic [ptp_tc_pkg::FNSEC_W-1:0] mem_dly,
	output logic go,
	output logic capt_ena,
	output logic capt_read,
	output logic [1:0] start_tod_sync,
	output logic [CAPT_ADDR_W-1:0] mem_rdaddr
);
	import ptp_tc_pkg::*;

	logic wb_req;
	logic wb_wr;
	logic [CSR_DW-1:0] rd_data;

	// One access per stb, ack blocks a second request
	assign wb_req = wb_cyc & wb_stb & ~wb_ack;
	assign wb_wr = wb_req & wb_we;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			wb_ack <= 1'b0;
			wb_dat_r <= '0;
		end else begin
			wb_ack <= wb_req;
			if (wb_req)
				wb_dat_r <= rd_data;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			go <= 1'b0;
			capt_ena <= 1'b0;
			capt_read <= 1'b0;
			start_tod_sync <= 2'b00;
			mem_rdaddr <= '0;
		end else if (wb_wr) begin
			case (wb_adr)
				REG_CTRL: begin
					go <= wb_dat_w[CTRL_GO];
					capt_ena <= wb_dat_w[CTRL_CAPT_ENA];
					capt_read <= wb_dat_w[CTRL_CAPT_READ];
					start_tod_sync <= wb_dat_w[CTRL_TOD_LSB +: 2];
				end
				REG_MEM_ADDR: mem_rdaddr <= wb_dat_w[CAPT_ADDR_W-1:0];
				default: ;
			endcase
		end
	end

	// Upper halves of the 48-bit words are zero extended
	always_comb begin
		rd_data = '0;
		case (wb_adr)
			REG_CTRL: begin
				rd_data[CTRL_GO] = go;
				rd_data[CTRL_CAPT_ENA] = capt_ena;
				rd_data[CTRL_CAPT_READ] = capt_read;
				rd_data[CTRL_TOD_LSB +: 2] = start_tod_sync;
			end
			REG_STATUS:
				rd_data[4:0] = {channels_ready, sec_error, crc_slave, crc_master, capt_done};
			REG_AVG_OFS_LO: rd_data = avg_ofs[CSR_DW-1:0];
			REG_AVG_OFS_HI: rd_data[FNSEC_W-CSR_DW-1:0] = avg_ofs[FNSEC_W-1:CSR_DW];
			REG_AVG_DLY_LO: rd_data = avg_dly[CSR_DW-1:0];
			REG_AVG_DLY_HI: rd_data[FNSEC_W-CSR_DW-1:0] = avg_dly[FNSEC_W-1:CSR_DW];
			REG_MEM_ADDR: rd_data[CAPT_ADDR_W-1:0] = mem_rdaddr;
			REG_MEM_OFS_LO: rd_data = mem_ofs[CSR_DW-1:0];
			REG_MEM_OFS_HI: rd_data[FNSEC_W-CSR_DW-1:0] = mem_ofs[FNSEC_W-1:CSR_DW];
			REG_MEM_DLY_LO: rd_data = mem_dly[CSR_DW-1:0];
			REG_MEM_DLY_HI: rd_data[FNSEC_W-CSR_DW-1:0] = mem_dly[FNSEC_W-1:CSR_DW];
			default: rd_data = '0;
		endcase
	end

	assert property (@(posedge clk) disable iff (!reset_n) wb_ack |-> $past(wb_stb))
		else $error("wb_ack without stb in the previous cycle");

endmodule

// ==== common/ptp_tc_pkg.sv ====
package ptp_tc_pkg;

	localparam int FNSEC_W = 48;
	localparam int SEC_W = 48;
	localparam int SAMPLE_W = SEC_W + FNSEC_W;

	localparam int CSR_AW = 6;
	localparam int CSR_DW = 32;

	// Wishbone word addresses
	localparam logic [CSR_AW-1:0] REG_CTRL = 6'd0;
	localparam logic [CSR_AW-1:0] REG_STATUS = 6'd1;
	localparam logic [CSR_AW-1:0] REG_AVG_OFS_LO = 6'd2;
	localparam logic [CSR_AW-1:0] REG_AVG_OFS_HI = 6'd3;
	localparam logic [CSR_AW-1:0] REG_AVG_DLY_LO = 6'd4;
	localparam logic [CSR_AW-1:0] REG_AVG_DLY_HI = 6'd5;
	localparam logic [CSR_AW-1:0] REG_MEM_ADDR = 6'd6;
	localparam logic [CSR_AW-1:0] REG_MEM_OFS_LO = 6'd7;
	localparam logic [CSR_AW-1:0] REG_MEM_OFS_HI = 6'd8;
	localparam logic [CSR_AW-1:0] REG_MEM_DLY_LO = 6'd9;
	localparam logic [CSR_AW-1:0] REG_MEM_DLY_HI = 6'd10;

	// Control register bits, start_tod_sync sits at 5:4
	localparam int CTRL_GO = 0;
	localparam int CTRL_CAPT_ENA = 1;
	localparam int CTRL_CAPT_READ = 2;
	localparam int CTRL_TOD_LSB = 4;

	// CRC bit of the 6-bit receive error vector
	localparam int RX_ERR_CRC = 1;

	typedef struct packed {
		logic [SEC_W-1:0] sec;
		logic [FNSEC_W-1:0] fnsec;
	} ptp_sample_t;

	// Raw word as received, or split into seconds and fractional ns
	typedef union packed {
		logic [SAMPLE_W-1:0] raw;
		ptp_sample_t f;
	} ptp_sample_u;

endpackage
